//--- Makefile
VERILATOR ?= verilator
TOP       ?= xm_regs_tb
RTL_TOP   ?= xm_regs
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Isource source/xm_pkg.sv source/host_bus_sync.sv \
		source/tick_timer.sv source/vram_xr_port.sv source/xm_regs.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+source
source/xm_pkg.sv
source/host_bus_sync.sv
source/tick_timer.sv
source/vram_xr_port.sv
source/xm_regs.sv
testbench/xm_regs_asserts.sv
testbench/xm_regs_checker.sv
testbench/xm_regs_tb.sv

//--- source/host_bus_sync.sv
// host bus synchronizer, latches one byte access and emits a read or write strobe
`timescale 1ns/1ps

module host_bus_sync import xm_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,         // async chip select, active low
    input  logic        bus_rd_nwr_i,       // 1 read, 0 write
    input  logic [3:0]  bus_reg_num_i,      // register number
    input  logic        bus_bytesel_i,      // 0 even byte, 1 odd byte
    input  byte_t       bus_data_i,         // write data from host
    output logic        write_strobe_o,     // one cycle per byte write
    output logic        read_strobe_o,      // one cycle per byte read
    output logic [3:0]  reg_num_o,          // held until next access
    output logic        bytesel_o,
    output byte_t       data_byte_o
);

logic   cs_meta;                            // first sync stage
logic   cs_sync;                            // second sync stage
logic   cs_last;                            // synced value one clock ago
logic   cs_fall;                            // select just went active

assign cs_fall = cs_last & ~cs_sync;

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_meta         <= 1'b1;            // bus idle
        cs_sync         <= 1'b1;
        cs_last         <= 1'b1;
        write_strobe_o  <= 1'b0;
        read_strobe_o   <= 1'b0;
    end else begin
        cs_meta         <= bus_cs_n_i;
        cs_sync         <= cs_meta;
        cs_last         <= cs_sync;
        write_strobe_o  <= cs_fall & ~bus_rd_nwr_i;
        read_strobe_o   <= cs_fall & bus_rd_nwr_i;
    end
end

// host keeps the fields stable well past the sync delay
always_ff @(posedge clk) begin
    if (cs_fall) begin
        reg_num_o       <= bus_reg_num_i;
        bytesel_o       <= bus_bytesel_i;
        data_byte_o     <= bus_data_i;
    end
end

endmodule

//--- source/tick_timer.sv
// free-running tenth-millisecond timer from a fractional divider of the pixel clock
`timescale 1ns/1ps
`include "xm_defines.svh"

module tick_timer import xm_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    output word_t   timer_o                 // counts 1/10 ms, wraps
);

localparam int  CLK_REDUCED = `XM_PCLK_HZ / 1000;       // clocks per 1/HZ_REDUCED tick
localparam int  HZ_REDUCED  = `XM_TIMER_HZ_REDUCED;
localparam int  FRAC_BITS   = $clog2(CLK_REDUCED) + 1;  // room for the sign bit

localparam logic signed [FRAC_BITS-1:0] STEP_IDLE = FRAC_BITS'(HZ_REDUCED);
localparam logic signed [FRAC_BITS-1:0] STEP_TICK = FRAC_BITS'(HZ_REDUCED - CLK_REDUCED);

logic signed [FRAC_BITS-1:0]    frac;      // fractional accumulator
logic                           tick;

assign tick = ~frac[FRAC_BITS-1];           // non-negative means a tick is due

always_ff @(posedge clk) begin
    if (reset_i) begin
        frac    <= '0;
        timer_o <= '0;
    end else begin
        if (tick) begin
            frac    <= frac + STEP_TICK;    // pay back one period
            timer_o <= timer_o + 1'b1;
        end else begin
            frac    <= frac + STEP_IDLE;
        end
    end
end

endmodule

//--- source/vram_xr_port.sv
// VRAM and XR access port with auto-increment addresses, write assembly and read-ahead
`timescale 1ns/1ps
`include "xm_defines.svh"

module vram_xr_port import xm_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        write_strobe_i,     // byte write from host
    input  logic        read_strobe_i,      // byte read from host
    input  logic [3:0]  reg_num_i,
    input  logic        bytesel_i,          // 0 even, 1 odd
    input  byte_t       data_byte_i,
    input  logic        vram_ack_i,         // one cycle, ends a VRAM request
    input  logic        xr_ack_i,           // one cycle, ends an XR request
    input  word_t       regs_data_i,        // VRAM read data
    input  word_t       xr_data_i,          // XR read data
    output logic        regs_vram_sel_o,
    output logic        regs_xr_sel_o,
    output logic        regs_wr_o,          // request is a write
    output addr_t       regs_addr_o,
    output word_t       regs_data_o,
    output logic        mem_wait_o,         // any request outstanding
    output word_t       rd_xaddr_o,
    output word_t       wr_xaddr_o,
    output word_t       xdata_o,            // last XR word read
    output word_t       rd_incr_o,
    output word_t       rd_addr_o,
    output word_t       wr_incr_o,
    output word_t       wr_addr_o,
    output word_t       data_o              // last VRAM word read
);

logic       vram_rd;                        // VRAM read outstanding
logic       xr_rd;                          // XR read outstanding
logic       rd_incr_flag;                   // step rd_addr next cycle
logic       wr_incr_flag;
logic       xrd_incr_flag;
logic       xwr_incr_flag;
logic       wr_even;
logic       wr_odd;
logic       rd_odd;
logic       is_data;                        // DATA or DATA_2
byte_t      even_q;                         // held even byte of a data write
byte_pair_u wr_word;                        // assembled write word

// merge one host byte into a word
function automatic word_t put_byte(input word_t w, input logic odd, input byte_t b);
    byte_pair_u p;
    p.word = w;
    if (odd) begin
        p.bytes.odd = b;
    end else begin
        p.bytes.even = b;
    end
    return p.word;
endfunction

assign wr_even    = write_strobe_i & ~bytesel_i;
assign wr_odd     = write_strobe_i & bytesel_i;
assign rd_odd     = read_strobe_i & bytesel_i;  // odd read ends a word read
assign is_data    = (reg_num_i == `XM_DATA) || (reg_num_i == `XM_DATA_2);
assign mem_wait_o = regs_wr_o | vram_rd | xr_rd;

always_comb begin
    wr_word.bytes.even = even_q;
    wr_word.bytes.odd  = data_byte_i;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        regs_vram_sel_o <= 1'b0;
        regs_xr_sel_o   <= 1'b0;
        regs_wr_o       <= 1'b0;
        vram_rd         <= 1'b0;
        xr_rd           <= 1'b0;
        rd_incr_flag    <= 1'b0;
        wr_incr_flag    <= 1'b0;
        xrd_incr_flag   <= 1'b0;
        xwr_incr_flag   <= 1'b0;
        rd_xaddr_o      <= '0;
        wr_xaddr_o      <= '0;
        rd_incr_o       <= '0;
        rd_addr_o       <= '0;
        wr_incr_o       <= '0;
        wr_addr_o       <= '0;
    end else begin
        rd_incr_flag    <= 1'b0;            // flags last one cycle
        wr_incr_flag    <= 1'b0;
        xrd_incr_flag   <= 1'b0;
        xwr_incr_flag   <= 1'b0;

        if (vram_ack_i) begin
            rd_incr_flag    <= vram_rd;
            wr_incr_flag    <= regs_wr_o;
            regs_vram_sel_o <= 1'b0;
            regs_wr_o       <= 1'b0;
            vram_rd         <= 1'b0;
        end
        if (xr_ack_i) begin
            xrd_incr_flag   <= xr_rd;
            xwr_incr_flag   <= regs_wr_o;
            regs_xr_sel_o   <= 1'b0;
            regs_wr_o       <= 1'b0;
            xr_rd           <= 1'b0;
        end

        // address steps, second cycle after the ack
        if (rd_incr_flag) begin
            rd_addr_o <= rd_addr_o + rd_incr_o;
        end
        if (wr_incr_flag) begin
            wr_addr_o <= wr_addr_o + wr_incr_o;
        end
        if (xrd_incr_flag) begin
            rd_xaddr_o <= rd_xaddr_o + 1'b1;
        end
        if (xwr_incr_flag) begin
            wr_xaddr_o <= wr_xaddr_o + 1'b1;
        end

        if (write_strobe_i) begin
            case (reg_num_i)
                `XM_RD_XADDR: rd_xaddr_o <= put_byte(rd_xaddr_o, bytesel_i, data_byte_i);
                `XM_WR_XADDR: wr_xaddr_o <= put_byte(wr_xaddr_o, bytesel_i, data_byte_i);
                `XM_RD_INCR:  rd_incr_o  <= put_byte(rd_incr_o, bytesel_i, data_byte_i);
                `XM_RD_ADDR:  rd_addr_o  <= put_byte(rd_addr_o, bytesel_i, data_byte_i);
                `XM_WR_INCR:  wr_incr_o  <= put_byte(wr_incr_o, bytesel_i, data_byte_i);
                `XM_WR_ADDR:  wr_addr_o  <= put_byte(wr_addr_o, bytesel_i, data_byte_i);
                default: begin
                end
            endcase
        end

        // request starts
        if ((wr_odd && reg_num_i == `XM_RD_ADDR) || (rd_odd && is_data)) begin
            regs_vram_sel_o <= 1'b1;        // read or pre-read
            vram_rd         <= 1'b1;
        end
        if ((wr_odd && reg_num_i == `XM_RD_XADDR) || (rd_odd && reg_num_i == `XM_XDATA)) begin
            regs_xr_sel_o   <= 1'b1;
            xr_rd           <= 1'b1;
        end
        if (wr_odd && is_data) begin
            regs_vram_sel_o <= 1'b1;
            regs_wr_o       <= 1'b1;
        end
        if (wr_odd && reg_num_i == `XM_XDATA) begin
            regs_xr_sel_o   <= 1'b1;
            regs_wr_o       <= 1'b1;
        end
    end
end

// request address/data and captured read words
always_ff @(posedge clk) begin
    if (vram_ack_i && vram_rd) begin
        data_o <= regs_data_i;
    end
    if (xr_ack_i && xr_rd) begin
        xdata_o <= xr_data_i;
    end
    if (wr_even && (is_data || reg_num_i == `XM_XDATA)) begin
        even_q <= data_byte_i;              // wait for the odd half
    end
    if (wr_odd) begin
        case (reg_num_i)
            `XM_RD_ADDR:  regs_addr_o <= put_byte(rd_addr_o, 1'b1, data_byte_i);
            `XM_RD_XADDR: regs_addr_o <= put_byte(rd_xaddr_o, 1'b1, data_byte_i);
            `XM_DATA, `XM_DATA_2: begin
                regs_addr_o <= wr_addr_o;
                regs_data_o <= wr_word.word;
            end
            `XM_XDATA: begin
                regs_addr_o <= wr_xaddr_o;
                regs_data_o <= wr_word.word;
            end
            default: begin
            end
        endcase
    end
    if (rd_odd && is_data) begin
        regs_addr_o <= rd_addr_o;           // next VRAM word ahead
    end
    if (rd_odd && reg_num_i == `XM_XDATA) begin
        regs_addr_o <= rd_xaddr_o;          // next XR word ahead
    end
end

endmodule

//--- source/xm_defines.svh
// host register block widths, register numbers, clock rate and reset values
`ifndef XM_DEFINES_SVH
`define XM_DEFINES_SVH

`define XM_WORD_W               16          // data and address width
`define XM_INTR_W               7           // interrupt sources
`define XM_PCLK_HZ              1000000     // pixel clock, multiple of 1000
`define XM_TIMER_HZ_REDUCED     10          // divider step added per clock
`define XM_WRMASK_RESET         4'b1111     // all four nibbles writable

// host register numbers
`define XM_SYS_CTRL             4'h0        // mem_wait, blanking, write mask
`define XM_INT_CTRL             4'h1        // interrupt mask and status/clear
`define XM_TIMER                4'h2        // tenth-ms timer
`define XM_RD_XADDR             4'h3        // XR read address
`define XM_WR_XADDR             4'h4        // XR write address
`define XM_XDATA                4'h5        // XR data port
`define XM_RD_INCR              4'h6        // VRAM read increment
`define XM_RD_ADDR              4'h7        // VRAM read address
`define XM_WR_INCR              4'h8        // VRAM write increment
`define XM_WR_ADDR              4'h9        // VRAM write address
`define XM_DATA                 4'hA        // VRAM data port
`define XM_DATA_2               4'hB        // VRAM data port alias

`endif

//--- source/xm_pkg.sv
// data types shared by the host register block
`include "xm_defines.svh"

package xm_pkg;

typedef logic [`XM_WORD_W-1:0]  word_t;     // register / memory word
typedef logic [`XM_WORD_W-1:0]  addr_t;     // VRAM or XR address
typedef logic [7:0]             byte_t;     // host bus byte
typedef logic [`XM_INTR_W-1:0]  intr_t;     // one bit per interrupt source

// one word seen whole or as the two host bus bytes
typedef union packed {
    word_t          word;                   // full 16 bits
    struct packed {
        byte_t      even;                   // high byte, bytesel 0
        byte_t      odd;                    // low byte, bytesel 1
    } bytes;
} byte_pair_u;

endpackage

//--- source/xm_regs.sv
// host register block top, control registers, timer latch and bus read mux
`timescale 1ns/1ps
`include "xm_defines.svh"

module xm_regs import xm_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,         // chip select, active low
    input  logic        bus_rd_nwr_i,       // 1 read, 0 write
    input  logic [3:0]  bus_reg_num_i,
    input  logic        bus_bytesel_i,      // 0 even, 1 odd
    input  byte_t       bus_data_i,
    output byte_t       bus_data_o,
    input  logic        vram_ack_i,
    input  logic        xr_ack_i,
    input  word_t       regs_data_i,        // VRAM read data
    input  word_t       xr_data_i,          // XR read data
    input  logic        h_blank_i,
    input  logic        v_blank_i,
    input  intr_t       intr_status_i,      // pending interrupts
    output logic        regs_vram_sel_o,
    output logic        regs_xr_sel_o,
    output logic        regs_wr_o,
    output logic [3:0]  regs_wrmask_o,      // VRAM nibble write enables
    output addr_t       regs_addr_o,
    output word_t       regs_data_o,
    output intr_t       intr_mask_o,        // enabled interrupts
    output intr_t       intr_clear_o        // one-cycle clear pulse
);

logic       write_strobe;
logic       read_strobe;
logic [3:0] reg_num;
logic       bytesel;
byte_t      data_byte;
word_t      timer;
byte_t      timer_lo;                       // low byte held at high byte read
logic       mem_wait;
word_t      rd_xaddr;
word_t      wr_xaddr;
word_t      xdata;
word_t      rd_incr;
word_t      rd_addr;
word_t      wr_incr;
word_t      wr_addr;
word_t      data;
byte_pair_u rd_pair;                        // selected read word

host_bus_sync host_bus_sync_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .write_strobe_o (write_strobe),
    .read_strobe_o  (read_strobe),
    .reg_num_o      (reg_num),
    .bytesel_o      (bytesel),
    .data_byte_o    (data_byte)
);

tick_timer tick_timer_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .timer_o        (timer)
);

vram_xr_port vram_xr_port_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .write_strobe_i  (write_strobe),
    .read_strobe_i   (read_strobe),
    .reg_num_i       (reg_num),
    .bytesel_i       (bytesel),
    .data_byte_i     (data_byte),
    .vram_ack_i      (vram_ack_i),
    .xr_ack_i        (xr_ack_i),
    .regs_data_i     (regs_data_i),
    .xr_data_i       (xr_data_i),
    .regs_vram_sel_o (regs_vram_sel_o),
    .regs_xr_sel_o   (regs_xr_sel_o),
    .regs_wr_o       (regs_wr_o),
    .regs_addr_o     (regs_addr_o),
    .regs_data_o     (regs_data_o),
    .mem_wait_o      (mem_wait),
    .rd_xaddr_o      (rd_xaddr),
    .wr_xaddr_o      (wr_xaddr),
    .xdata_o         (xdata),
    .rd_incr_o       (rd_incr),
    .rd_addr_o       (rd_addr),
    .wr_incr_o       (wr_incr),
    .wr_addr_o       (wr_addr),
    .data_o          (data)
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        regs_wrmask_o <= `XM_WRMASK_RESET;
        intr_mask_o   <= '0;
        intr_clear_o  <= '0;
    end else begin
        intr_clear_o  <= '0;                // clears are pulses
        if (write_strobe && reg_num == `XM_SYS_CTRL && bytesel) begin
            regs_wrmask_o <= data_byte[3:0];
        end
        if (write_strobe && reg_num == `XM_INT_CTRL) begin
            if (bytesel) begin
                intr_clear_o <= data_byte[6:0];
            end else begin
                intr_mask_o  <= data_byte[6:0];
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (read_strobe && !bytesel) begin
        timer_lo <= timer[7:0];             // any even read, keeps TIMER coherent
    end
end

always_comb begin
    case (reg_num)
        `XM_SYS_CTRL: rd_pair.word = {mem_wait, 2'b00, h_blank_i, v_blank_i, 7'b0, regs_wrmask_o};
        `XM_INT_CTRL: rd_pair.word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
        `XM_TIMER:    rd_pair.word = {timer[15:8], timer_lo};   // live high, latched low
        `XM_RD_XADDR: rd_pair.word = rd_xaddr;
        `XM_WR_XADDR: rd_pair.word = wr_xaddr;
        `XM_XDATA:    rd_pair.word = xdata;
        `XM_RD_INCR:  rd_pair.word = rd_incr;
        `XM_RD_ADDR:  rd_pair.word = rd_addr;
        `XM_WR_INCR:  rd_pair.word = wr_incr;
        `XM_WR_ADDR:  rd_pair.word = wr_addr;
        `XM_DATA, `XM_DATA_2: rd_pair.word = data;
        default:      rd_pair.word = '0;        // unused registers
    endcase
end

assign bus_data_o = bytesel ? rd_pair.bytes.odd : rd_pair.bytes.even;

endmodule

//--- testbench/xm_regs_asserts.sv
// handshake assertions on the VRAM and XR request signals
`timescale 1ns/1ps

module xm_regs_asserts (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    regs_vram_sel_o,
    input  logic    regs_xr_sel_o,
    input  logic    regs_wr_o,
    input  logic    vram_ack_i,
    input  logic    xr_ack_i
);

int fail_count = 0;                         // read by the checker

one_select: assert property (@(posedge clk) disable iff (reset_i)
    !(regs_vram_sel_o && regs_xr_sel_o))
    else begin
        fail_count++;
        $error("VRAM and XR selects high together");
    end

write_has_select: assert property (@(posedge clk) disable iff (reset_i)
    regs_wr_o |-> (regs_vram_sel_o || regs_xr_sel_o))
    else begin
        fail_count++;
        $error("write request without a select");
    end

vram_sel_held: assert property (@(posedge clk) disable iff (reset_i)
    (regs_vram_sel_o && !vram_ack_i) |=> regs_vram_sel_o)
    else begin
        fail_count++;
        $error("VRAM select dropped before its ack");
    end

xr_sel_held: assert property (@(posedge clk) disable iff (reset_i)
    (regs_xr_sel_o && !xr_ack_i) |=> regs_xr_sel_o)
    else begin
        fail_count++;
        $error("XR select dropped before its ack");
    end

endmodule

bind vram_xr_port xm_regs_asserts asserts_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .regs_vram_sel_o (regs_vram_sel_o),
    .regs_xr_sel_o   (regs_xr_sel_o),
    .regs_wr_o       (regs_wr_o),
    .vram_ack_i      (vram_ack_i),
    .xr_ack_i        (xr_ack_i)
);

//--- testbench/xm_regs_checker.sv
// checker for the host register block, reference functions, write compare and error counts
`timescale 1ns/1ps
`include "xm_defines.svh"

module xm_regs_checker import xm_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    vram_sel_i,
    input  logic    xr_sel_i,
    input  logic    wr_i,
    input  addr_t   addr_i,
    input  word_t   wdata_i,
    input  logic    vram_ack_i,
    input  logic    xr_ack_i,
    input  intr_t   intr_clear_i
);

int     checks = 0;
int     compare_errors = 0;
int     clear_cycles = 0;                   // cycles with a clear pulse
intr_t  clear_value = '0;
string  exp_name_q[$];                      // expected write requests
addr_t  exp_addr_q[$];
word_t  exp_data_q[$];
word_t  shadow_vram [0:65535];
word_t  shadow_xr [0:255];                  // indexed by address low byte

// k-th address of a stream, wraps at 16 bits
function automatic addr_t stream_addr(input addr_t base, input word_t incr, input int k);
    logic [31:0] full;
    full = 32'(base) + 32'(incr) * 32'(k);
    return full[15:0];
endfunction

function automatic word_t sys_ctrl_word(input logic wait_b, input logic hb, input logic vb,
                                        input logic [3:0] mask);
    return {wait_b, 2'b00, hb, vb, 7'b0, mask};
endfunction

function automatic word_t int_ctrl_word(input intr_t mask, input intr_t status);
    return {1'b0, mask, 1'b0, status};
endfunction

// timer ticks in a span of clocks
function automatic int ticks_for(input int cycles);
    return cycles / (`XM_PCLK_HZ / 10000);
endfunction

function automatic int error_count();
    return compare_errors + xm_regs_tb.xm_regs_inst.vram_xr_port_inst.asserts_inst.fail_count;
endfunction

task automatic check_value(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
        compare_errors++;
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_range(input string name, input int exp, input int act, input int tol);
    checks++;
    if (act < exp - tol || act > exp + tol) begin
        compare_errors++;
        $display("FAIL %s: expected %0d +/- %0d, actual %0d", name, exp, tol, act);
    end
endtask

task automatic note_failure(input string what);
    compare_errors++;
    $display("error: %s", what);
endtask

task automatic expect_write(input string name, input addr_t addr, input word_t data);
    exp_name_q.push_back(name);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
endtask

task automatic compare_write(input logic is_vram);
    string  name;
    addr_t  a;
    word_t  d;
    if (exp_name_q.size() == 0) begin
        note_failure($sformatf("unexpected write request to address %h", addr_i));
    end else begin
        name = exp_name_q.pop_front();
        a    = exp_addr_q.pop_front();
        d    = exp_data_q.pop_front();
        check_value({name, "_addr"}, a, addr_i);
        check_value({name, "_data"}, d, wdata_i);
        if (is_vram) begin
            shadow_vram[a] = d;             // expected word, not the DUT's
        end else begin
            shadow_xr[a[7:0]] = d;
        end
    end
endtask

// mid-cycle sampling, ack and select both settled
always @(negedge clk) begin
    if (!reset_i && vram_ack_i && vram_sel_i && wr_i) begin
        compare_write(1'b1);
    end
    if (!reset_i && xr_ack_i && xr_sel_i && wr_i) begin
        compare_write(1'b0);
    end
    if (!reset_i && intr_clear_i != '0) begin
        clear_cycles++;                     // pulse width
        clear_value = intr_clear_i;
    end
end

task automatic report();
    if (exp_name_q.size() != 0) begin
        note_failure($sformatf("%0d expected writes never issued", exp_name_q.size()));
    end
    $display("checks: %0d, errors: %0d (compare %0d, assertion %0d)", checks,
             error_count(), compare_errors, error_count() - compare_errors);
endtask

endmodule

//--- testbench/xm_regs_tb.sv
// testbench top for the host register block, bus host, memory models and watchdog
`timescale 1ns/1ps
`include "xm_defines.svh"

module xm_regs_tb import xm_pkg::*; ();

localparam int  CLK_PERIOD   = 100;
localparam int  RESET_CYCLES = 16;
localparam int  STREAM_LEN   = 8;           // words per VRAM stream
localparam int  XR_LEN       = 4;
localparam int  TIMER_GAP    = 3000;        // clocks between timer reads
localparam int  WORD_CYC     = 40;          // one register access incl. polling
localparam int  WORD_COUNT   = 70;
localparam int  TEST_CYCLES  = RESET_CYCLES + WORD_COUNT * WORD_CYC + TIMER_GAP;

logic       clk;
logic       reset_i;
logic       bus_cs_n_i;
logic       bus_rd_nwr_i;
logic [3:0] bus_reg_num_i;
logic       bus_bytesel_i;
byte_t      bus_data_i;
byte_t      bus_data_o;
logic       vram_ack_i;
logic       xr_ack_i;
word_t      regs_data_i;
word_t      xr_data_i;
logic       h_blank_i;
logic       v_blank_i;
intr_t      intr_status_i;
logic       regs_vram_sel_o;
logic       regs_xr_sel_o;
logic       regs_wr_o;
logic [3:0] regs_wrmask_o;
addr_t      regs_addr_o;
word_t      regs_data_o;
intr_t      intr_mask_o;
intr_t      intr_clear_o;
int         cyc_count;                      // clocks since reset release
int         even_cyc;                       // strobe clock of the last even read
word_t      vram_mem [0:65535];
word_t      xr_mem [0:255];

xm_regs xm_regs_inst (.*);

xm_regs_checker chk (
    .clk (clk), .reset_i (reset_i), .vram_sel_i (regs_vram_sel_o),
    .xr_sel_i (regs_xr_sel_o), .wr_i (regs_wr_o), .addr_i (regs_addr_o),
    .wdata_i (regs_data_o), .vram_ack_i (vram_ack_i), .xr_ack_i (xr_ack_i),
    .intr_clear_i (intr_clear_o)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk) begin
    cyc_count <= reset_i ? 0 : cyc_count + 1;
end

// VRAM answers after 1 to 4 clocks
initial begin : vram_model
    int d;
    vram_ack_i  = 1'b0;
    regs_data_i = '0;
    forever begin
        @(posedge clk);
        #1;
        if (regs_vram_sel_o && !reset_i) begin
            d = int'($urandom_range(4, 1));
            #4;
            repeat (d - 1) begin
                @(posedge clk);
                #5;
            end
            if (regs_wr_o) vram_mem[regs_addr_o] = regs_data_o;
            else regs_data_i = vram_mem[regs_addr_o];
            vram_ack_i = 1'b1;
            @(posedge clk);
            #5 vram_ack_i = 1'b0;
        end
    end
end

initial begin : xr_model
    int d;
    xr_ack_i  = 1'b0;
    xr_data_i = '0;
    forever begin
        @(posedge clk);
        #1;
        if (regs_xr_sel_o && !reset_i) begin
            d = int'($urandom_range(4, 1));
            #4;
            repeat (d - 1) begin
                @(posedge clk);
                #5;
            end
            if (regs_wr_o) xr_mem[regs_addr_o[7:0]] = regs_data_o;  // low byte index
            else xr_data_i = xr_mem[regs_addr_o[7:0]];
            xr_ack_i = 1'b1;
            @(posedge clk);
            #5 xr_ack_i = 1'b0;
        end
    end
end

initial begin : watchdog
    repeat (2 * TEST_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d clocks", 2 * TEST_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
end

// one byte access, cs low 5 clocks then high 4
task automatic bus_cycle(input logic rd, input logic [3:0] rnum, input logic odd,
                         input byte_t wdata, output byte_t rdata);
    @(posedge clk);
    #5;
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = rnum;
    bus_bytesel_i = odd;
    bus_data_i    = wdata;
    repeat (3) @(posedge clk);
    #10;
    rdata = bus_data_o;                     // strobe done, pre-read not yet back
    if (rd && !odd) even_cyc = cyc_count;
    repeat (2) @(posedge clk);
    #5 bus_cs_n_i = 1'b1;
    repeat (4) @(posedge clk);
endtask

task automatic wait_idle();
    byte_t  b;
    int     tries;
    tries = 0;
    do begin
        bus_cycle(1'b1, `XM_SYS_CTRL, 1'b0, 8'h00, b);
        tries++;
    end while (b[7] && tries < 20);
    if (b[7]) chk.note_failure("mem_wait stayed high");
endtask

task automatic reg_write(input logic [3:0] rnum, input word_t w);
    byte_t  unused;
    wait_idle();
    bus_cycle(1'b0, rnum, 1'b0, w[15:8], unused);
    bus_cycle(1'b0, rnum, 1'b1, w[7:0], unused);
endtask

task automatic reg_read(input logic [3:0] rnum, output word_t w);
    wait_idle();
    bus_cycle(1'b1, rnum, 1'b0, 8'h00, w[15:8]);
    bus_cycle(1'b1, rnum, 1'b1, 8'h00, w[7:0]);
endtask

task automatic test_reset();
    word_t  got;
    if (regs_vram_sel_o || regs_xr_sel_o) chk.note_failure("select high after reset");
    chk.check_value("reset_intr_mask", 16'h0, word_t'(intr_mask_o));
    reg_read(`XM_SYS_CTRL, got);
    chk.check_value("reset_sys_ctrl", chk.sys_ctrl_word(1'b0, 1'b0, 1'b0, 4'hF), got);
    reg_read(`XM_RD_XADDR, got);
    chk.check_value("reset_rd_xaddr", 16'h0, got);
    reg_read(`XM_WR_XADDR, got);
    chk.check_value("reset_wr_xaddr", 16'h0, got);
    reg_read(`XM_RD_ADDR, got);
    chk.check_value("reset_rd_addr", 16'h0, got);
    reg_read(`XM_WR_ADDR, got);
    chk.check_value("reset_wr_addr", 16'h0, got);
    reg_read(`XM_RD_INCR, got);
    chk.check_value("reset_rd_incr", 16'h0, got);
endtask

task automatic test_vram_write();
    addr_t  base;
    word_t  incr;
    word_t  w;
    word_t  got;
    base = word_t'($urandom);
    incr = word_t'($urandom_range(300, 1));
    reg_write(`XM_WR_INCR, incr);
    reg_write(`XM_WR_ADDR, base);
    for (int k = 0; k < STREAM_LEN; k++) begin
        w = word_t'($urandom);
        chk.expect_write("vram_write", chk.stream_addr(base, incr, k), w);
        reg_write(k[0] ? `XM_DATA_2 : `XM_DATA, w);
    end
    reg_read(`XM_WR_ADDR, got);
    chk.check_value("vram_wr_addr", chk.stream_addr(base, incr, STREAM_LEN), got);
endtask

task automatic test_vram_read();
    addr_t  base;
    addr_t  a;
    word_t  incr;
    word_t  got;
    base = word_t'($urandom);
    incr = word_t'($urandom_range(300, 1));
    for (int k = 0; k < STREAM_LEN; k++) begin
        a = chk.stream_addr(base, incr, k);
        vram_mem[a] = word_t'($urandom);
        chk.shadow_vram[a] = vram_mem[a];
    end
    reg_write(`XM_RD_INCR, incr);
    reg_write(`XM_RD_ADDR, base);           // first word fetched here
    for (int k = 0; k < STREAM_LEN; k++) begin
        reg_read(k[0] ? `XM_DATA_2 : `XM_DATA, got);
        chk.check_value("vram_read", chk.shadow_vram[chk.stream_addr(base, incr, k)], got);
    end
    reg_read(`XM_RD_ADDR, got);
    chk.check_value("vram_rd_addr", chk.stream_addr(base, incr, STREAM_LEN + 1), got);
endtask

task automatic test_xr();
    addr_t  base;
    word_t  w;
    word_t  got;
    base = word_t'($urandom_range(200, 0));
    reg_write(`XM_WR_XADDR, base);
    for (int k = 0; k < XR_LEN; k++) begin
        w = word_t'($urandom);
        chk.expect_write("xr_write", chk.stream_addr(base, 16'd1, k), w);
        reg_write(`XM_XDATA, w);
    end
    reg_read(`XM_WR_XADDR, got);
    chk.check_value("xr_wr_xaddr", chk.stream_addr(base, 16'd1, XR_LEN), got);
    reg_write(`XM_RD_XADDR, base);
    for (int k = 0; k < XR_LEN; k++) begin
        reg_read(`XM_XDATA, got);
        chk.check_value("xr_read", chk.shadow_xr[8'(base + k)], got);
    end
    reg_read(`XM_RD_XADDR, got);
    chk.check_value("xr_rd_xaddr", chk.stream_addr(base, 16'd1, XR_LEN + 1), got);
endtask

task automatic test_intr_status();
    byte_t  unused;
    word_t  got;
    #5 intr_status_i = 7'h2A;
    wait_idle();
    bus_cycle(1'b0, `XM_INT_CTRL, 1'b0, 8'h55, unused);
    chk.check_value("intr_mask", 16'h0055, word_t'(intr_mask_o));
    reg_read(`XM_INT_CTRL, got);
    chk.check_value("int_ctrl_read", chk.int_ctrl_word(7'h55, 7'h2A), got);
    chk.clear_cycles = 0;
    bus_cycle(1'b0, `XM_INT_CTRL, 1'b1, 8'h13, unused);
    chk.check_value("intr_clear_width", 16'd1, word_t'(chk.clear_cycles));
    chk.check_value("intr_clear_value", 16'h0013, word_t'(chk.clear_value));
    #5 h_blank_i = 1'b1;
    bus_cycle(1'b0, `XM_SYS_CTRL, 1'b1, 8'h05, unused);
    chk.check_value("wrmask", 16'h0005, word_t'(regs_wrmask_o));
    reg_read(`XM_SYS_CTRL, got);
    chk.check_value("sys_ctrl_hblank", chk.sys_ctrl_word(1'b0, 1'b1, 1'b0, 4'h5), got);
    #5 h_blank_i = 1'b0;
    v_blank_i = 1'b1;
    bus_cycle(1'b0, `XM_SYS_CTRL, 1'b1, 8'h0F, unused);
    reg_read(`XM_SYS_CTRL, got);
    chk.check_value("sys_ctrl_vblank", chk.sys_ctrl_word(1'b0, 1'b0, 1'b1, 4'hF), got);
endtask

task automatic test_timer();
    word_t  t1;
    word_t  t2;
    byte_t  lo;
    int     c1;
    reg_read(`XM_TIMER, t1);
    c1 = even_cyc;                          // low byte latched here
    chk.check_range("timer_first", chk.ticks_for(c1), int'(t1), 1);
    repeat (TIMER_GAP) @(posedge clk);
    bus_cycle(1'b1, `XM_TIMER, 1'b1, 8'h00, lo);    // odd byte alone, latch untouched
    chk.check_value("timer_lo_held", word_t'(t1[7:0]), word_t'(lo));
    reg_read(`XM_TIMER, t2);
    chk.check_range("timer_delta", chk.ticks_for(even_cyc - c1), int'(t2 - t1), 1);
endtask

initial begin
    void'($urandom(94));
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    h_blank_i     = 1'b0;
    v_blank_i     = 1'b0;
    intr_status_i = '0;
    even_cyc      = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5 reset_i = 1'b0;
    test_reset();
    test_vram_write();
    test_vram_read();
    test_xr();
    test_intr_status();
    test_timer();
    repeat (10) @(posedge clk);
    chk.report();
    if (chk.error_count() == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule
